/* Makefile */
# Verilator build and run of the string compare accelerator testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module stringAccel_tb \
		-f stringAccel.f --Mdir obj_dir -o simv

# Pass only when the simulation output holds the pass message
run: compile
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

/* stringAccel.f */
stringAccelPkg.sv
stringPort.sv
stringRegs.sv
stringCompare.sv
stringAccelTop.sv
stringAccel_checker.sv
stringAccel_tb.sv

/* stringAccelPkg.sv */
// ==========================================================================
// String accelerator shared definitions
// Default string size, control/status bit layout and the result record
// ==========================================================================
`default_nettype none

package stringAccelPkg;

	// Default 32-bit words per string
	parameter int MAX_WORDS = 8;

	// Width of the length and index fields
	parameter int LEN_WIDTH = 8;

	// Control/status word layout
	// done is set by the engine and cleared by any control write
	parameter int CTRL_DONE = 0;
	// go doubles as busy until the engine reports done
	parameter int CTRL_GO = 1;
	parameter int CTRL_MATCH = 2;
	// Byte index of the first difference, bits 15..8
	parameter int CTRL_INDEX_LSB = 8;
	// Length of string A, bits 23..16
	parameter int CTRL_LENGTH_LSB = 16;

	// Outcome of one compare run
	typedef struct packed {
		logic [LEN_WIDTH-1:0] length;
		logic [LEN_WIDTH-1:0] index;
		logic                 match;
	} strResult_t;

endpackage

`default_nettype wire

/* stringAccelTop.sv */
// ==========================================================================
// String compare accelerator top level
// Register block and compare engine joined by their port, plain bus pins
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module stringAccelTop #(
	parameter int maxWords = stringAccelPkg::MAX_WORDS,
	localparam int addrWidth = $clog2(2 * maxWords + 1)
) (
	input  logic                 clk,
	input  logic                 reset,
	// Slave bus
	input  logic [addrWidth-1:0] address,
	input  logic                 write,
	input  logic                 read,
	input  logic                 chipselect,
	input  logic [31:0]          writedata,
	output logic [31:0]          readdata
);

	// Word fetch, launch and result link
	stringPort #(
		.maxWords(maxWords)
	) strPort ();

	// Bus-facing registers and string storage
	stringRegs #(
		.maxWords(maxWords)
	) u_regs (
		.clk       (clk),
		.reset     (reset),
		.address   (address),
		.write     (write),
		.read      (read),
		.chipselect(chipselect),
		.writedata (writedata),
		.readdata  (readdata),
		.port      (strPort.regs)
	);

	// Word-serial compare
	stringCompare #(
		.maxWords(maxWords)
	) u_compare (
		.clk  (clk),
		.reset(reset),
		.port (strPort.engine)
	);

endmodule

`default_nettype wire

/* stringAccel_checker.sv */
// ==========================================================================
// String accelerator protocol checker
// Bound into the register block, watches launch, completion and read data
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module stringAccel_checker (
	input logic        clk,
	input logic        reset,
	input logic        start,
	input logic        busy,
	input logic        done,
	input logic        busRead,
	input logic [31:0] ctrlReg,
	input logic [31:0] readdata
);
	import stringAccelPkg::*;

	// Failed assertion count
	int failCount = 0;

	// Launch only into an idle engine
	startWhenIdle: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
		else begin
			failCount++;
			$error("start raised while the engine was busy");
		end

	// Done edge drops go and raises the done flag
	doneClearsGo: assert property (@(posedge clk) disable iff (reset)
		done |=> !ctrlReg[CTRL_GO] && ctrlReg[CTRL_DONE])
		else begin
			failCount++;
			$error("go still set or done missing after the done pulse");
		end

	// busy and done hand over in the same cycle
	busyFallsWithDone: assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> done)
		else begin
			failCount++;
			$error("busy fell without a done pulse");
		end
	doneEndsBusy: assert property (@(posedge clk) disable iff (reset)
		done |-> $fell(busy))
		else begin
			failCount++;
			$error("done pulsed without busy falling in the same cycle");
		end

	// Read data only moves after a read strobe
	readdataAfterRead: assert property (@(posedge clk) disable iff (reset)
		!$stable(readdata) |-> $past(busRead))
		else begin
			failCount++;
			$error("readdata changed without a preceding read");
		end

endmodule

`default_nettype wire

/* stringAccel_tb.sv */
// ==========================================================================
// String compare accelerator testbench
// Bus-level stimulus with LCG strings, checked against a byte-level model
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module stringAccel_tb;
	import stringAccelPkg::*;

	localparam int maxWords = MAX_WORDS;
	localparam int addrWidth = $clog2(2 * maxWords + 1);
	localparam int numBytes = 4 * maxWords;
	localparam logic [31:0] goWord = 32'h1 << CTRL_GO;

	logic                 clk;
	logic                 reset;
	logic [addrWidth-1:0] address;
	logic                 write;
	logic                 read;
	logic                 chipselect;
	logic [31:0]          writedata;
	logic [31:0]          readdata;

	// Byte images of the two strings
	logic [7:0]  strA [0:numBytes-1];
	logic [7:0]  strB [0:numBytes-1];
	logic [31:0] lcgState = 32'h94ea1d3d;
	int          errorCount = 0;
	int          timeoutCount = 0;

	stringAccelTop u_stringAccelTop (
		.clk       (clk),
		.reset     (reset),
		.address   (address),
		.write     (write),
		.read      (read),
		.chipselect(chipselect),
		.writedata (writedata),
		.readdata  (readdata)
	);

	bind stringRegs stringAccel_checker u_checker (
		.clk     (clk),
		.reset   (reset),
		.start   (port.start),
		.busy    (port.busy),
		.done    (port.done),
		.busRead (busRead),
		.ctrlReg (ctrlReg),
		.readdata(readdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Upper LCG bits, the low ones cycle quickly
	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = nextRand();
		return int'({8'h00, r[31:8]}) % n;
	endfunction

	task automatic writeWord(input int addr, input logic [31:0] data);
		address = addrWidth'(addr);
		writedata = data;
		write = 1'b1;
		chipselect = 1'b1;
		@(posedge clk);
		#1;
		write = 1'b0;
		chipselect = 1'b0;
	endtask

	// One-cycle latency, data taken after the edge
	task automatic readWord(input int addr, output logic [31:0] data);
		address = addrWidth'(addr);
		read = 1'b1;
		chipselect = 1'b1;
		@(posedge clk);
		#1;
		read = 1'b0;
		chipselect = 1'b0;
		data = readdata;
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			errorCount++;
			$display("** Error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	// Printable bytes everywhere, then the NUL, B a copy of A
	task automatic makeStrings(input int nulPos);
		for (int i = 0; i < numBytes; i++) begin
			strA[i] = 8'h20 + 8'(randBelow(95));
		end
		if (nulPos < numBytes) begin
			strA[nulPos] = 8'h00;
		end
		strB = strA;
	endtask

	task automatic setDiff(input int pos);
		strB[pos] = (strA[pos] == 8'h41) ? 8'h42 : 8'h41;
	endtask

	task automatic loadStrings();
		for (int w = 0; w < maxWords; w++) begin
			writeWord(1 + w, {strA[4*w+3], strA[4*w+2], strA[4*w+1], strA[4*w]});
			writeWord(1 + maxWords + w, {strB[4*w+3], strB[4*w+2], strB[4*w+1], strB[4*w]});
		end
	endtask

	// Scan to A's NUL, first difference wins, NUL byte itself compared
	task automatic computeModel(output int expLength, output int expIndex, output bit expMatch);
		bit found;
		found = 1'b0;
		expIndex = 0;
		expLength = numBytes;
		for (int i = 0; i < numBytes; i++) begin
			if (!found && strA[i] != strB[i]) begin
				found = 1'b1;
				expIndex = i;
			end
			if (strA[i] == 8'h00) begin
				expLength = i;
				break;
			end
		end
		expMatch = !found;
		if (!found) begin
			expIndex = expLength;
		end
	endtask

	task automatic waitDone(input string name, output logic [31:0] status);
		int polls;
		polls = 0;
		status = '0;
		while (!status[CTRL_DONE] && polls < 64) begin
			readWord(0, status);
			polls++;
		end
		if (!status[CTRL_DONE]) begin
			timeoutCount++;
			$display("Timeout: %s never reported done after %0d control reads", name, polls);
		end
	endtask

	task automatic checkResult(input string name, input logic [31:0] status);
		int expLength;
		int expIndex;
		bit expMatch;
		computeModel(expLength, expIndex, expMatch);
		checkValue({name, " done"}, 32'd1, 32'(status[CTRL_DONE]));
		checkValue({name, " go"}, 32'd0, 32'(status[CTRL_GO]));
		checkValue({name, " match"}, 32'(expMatch), 32'(status[CTRL_MATCH]));
		checkValue({name, " index"}, 32'(expIndex), 32'(status[CTRL_INDEX_LSB +: LEN_WIDTH]));
		checkValue({name, " length"}, 32'(expLength),
			32'(status[CTRL_LENGTH_LSB +: LEN_WIDTH]));
	endtask

	task automatic runCompare(input string name);
		logic [31:0] status;
		loadStrings();
		writeWord(0, goWord);
		waitDone(name, status);
		checkResult(name, status);
	endtask

	initial begin
		logic [31:0] data;
		logic [31:0] status;
		logic [31:0] oldWord;
		logic [31:0] expected [1:2*maxWords];
		int nul;
		int diff;
		int checkerFails;
		reset = 1'b1;
		address = '0;
		write = 1'b0;
		read = 1'b0;
		chipselect = 1'b0;
		writedata = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// Everything reads zero after reset
		readWord(0, data);
		checkValue("reset control", 32'h0, data);
		readWord(1, data);
		checkValue("reset A word", 32'h0, data);
		readWord(1 + maxWords, data);
		checkValue("reset B word", 32'h0, data);

		// Every string word, then control with go clear and done set
		for (int a = 1; a <= 2 * maxWords; a++) begin
			expected[a] = nextRand();
			writeWord(a, expected[a]);
		end
		for (int a = 1; a <= 2 * maxWords; a++) begin
			readWord(a, data);
			checkValue("readback string word", expected[a], data);
		end
		oldWord = (nextRand() & ~goWord) | 32'h1;
		writeWord(0, oldWord);
		readWord(0, data);
		checkValue("readback control", oldWord & ~32'h1, data);

		makeStrings(randBelow(numBytes));
		runCompare("equal strings");

		for (int n = 0; n < 4; n++) begin
			nul = 1 + randBelow(numBytes - 1);
			makeStrings(nul);
			setDiff(randBelow(nul));
			runCompare("random mismatch");
		end
		// Lane 3 of a word, then inside word 0, then B longer than A
		diff = 4 * randBelow(maxWords - 1) + 3;
		makeStrings(diff + 1 + randBelow(numBytes - diff - 1));
		setDiff(diff);
		runCompare("lane 3 mismatch");
		makeStrings(4 + randBelow(numBytes - 4));
		setDiff(randBelow(4));
		runCompare("word 0 mismatch");
		nul = randBelow(numBytes);
		makeStrings(nul);
		setDiff(nul);
		runCompare("B longer than A");

		makeStrings(numBytes);
		runCompare("full length equal");
		setDiff(numBytes - 1);
		runCompare("full length last byte");

		// B write and a second go while the engine runs
		makeStrings(4 + randBelow(numBytes - 4));
		loadStrings();
		oldWord = {strB[3], strB[2], strB[1], strB[0]};
		writeWord(0, goWord);
		writeWord(1 + maxWords, ~oldWord);
		writeWord(0, goWord);
		waitDone("busy lockout", status);
		checkResult("busy lockout", status);
		readWord(1 + maxWords, data);
		checkValue("busy lockout B word", oldWord, data);

		checkerFails = u_stringAccelTop.u_regs.u_checker.failCount;
		$display("Summary: %0d errors, %0d timeouts, %0d assertion failures",
			errorCount, timeoutCount, checkerFails);
		if (errorCount == 0 && timeoutCount == 0 && checkerFails == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* stringCompare.sv */
// ==========================================================================
// String compare engine
// Walks A and B one word per cycle and reports A's length, the first
// differing byte and whether the strings match through A's terminator
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module stringCompare #(
	parameter int maxWords = stringAccelPkg::MAX_WORDS
) (
	input logic        clk,
	input logic        reset,
	stringPort.engine  port
);
	import stringAccelPkg::*;

	localparam int idxWidth = (maxWords > 1) ? $clog2(maxWords) : 1;

	// Length of a string with no terminator
	localparam logic [LEN_WIDTH-1:0] fullLength = LEN_WIDTH'(4 * maxWords);

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		FINISH
	} compareState_t;

	compareState_t state;

	// Word under inspection
	logic [idxWidth-1:0] wordCount;

	// Sticky difference flag and its byte position
	logic                 mismatch;
	logic [LEN_WIDTH-1:0] firstDiff;

	strResult_t resultReg;

	// Per-word lane scan
	logic       nulSeen;
	logic       diffSeen;
	logic [1:0] nulLane;
	logic [1:0] diffLane;

	// Byte positions within the string
	logic [LEN_WIDTH-1:0] basePos;
	logic [LEN_WIDTH-1:0] diffPos;
	logic [LEN_WIDTH-1:0] endPos;

	logic lastWord;
	logic scanDone;

	// Lanes in order, nothing past A's NUL is compared
	always_comb begin
		nulSeen = 1'b0;
		diffSeen = 1'b0;
		nulLane = 2'd0;
		diffLane = 2'd0;
		for (int lane = 0; lane < 4; lane++) begin
			if (!nulSeen) begin
				// NUL lane itself still compared, catches a longer B
				if (!diffSeen && (port.wordA[8*lane +: 8] != port.wordB[8*lane +: 8])) begin
					diffSeen = 1'b1;
					diffLane = 2'(lane);
				end
				if (port.wordA[8*lane +: 8] == 8'h00) begin
					nulSeen = 1'b1;
					nulLane = 2'(lane);
				end
			end
		end
	end

	assign basePos = LEN_WIDTH'({wordCount, 2'b00});
	assign diffPos = basePos + LEN_WIDTH'(diffLane);
	assign endPos = nulSeen ? (basePos + LEN_WIDTH'(nulLane)) : fullLength;

	assign lastWord = (wordCount == idxWidth'(maxWords - 1));

	// A difference alone does not end the scan, A's length is still needed
	assign scanDone = nulSeen || lastWord;

	// Sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			wordCount <= '0;
			mismatch <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (port.start) begin
						state <= SCAN;
						wordCount <= '0;
						mismatch <= 1'b0;
					end
				end
				SCAN: begin
					if (diffSeen) begin
						mismatch <= 1'b1;
					end
					if (scanDone) begin
						state <= FINISH;
					end else begin
						wordCount <= wordCount + 1'b1;
					end
				end
				FINISH: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Result capture
	always_ff @(posedge clk) begin
		if (state == SCAN) begin
			// Keep only the earliest difference
			if (!mismatch && diffSeen) begin
				firstDiff <= diffPos;
			end
			if (scanDone) begin
				resultReg.length <= endPos;
				resultReg.match <= !(mismatch || diffSeen);
				if (mismatch) begin
					resultReg.index <= firstDiff;
				end else if (diffSeen) begin
					resultReg.index <= diffPos;
				end else begin
					// Identical through the terminator
					resultReg.index <= endPos;
				end
			end
		end
	end

	assign port.wordIndex = wordCount;
	// busy drops in the cycle done pulses
	assign port.busy = (state == SCAN);
	assign port.done = (state == FINISH);
	assign port.result = resultReg;

endmodule

`default_nettype wire

/* stringPort.sv */
// ==========================================================================
// Register block to compare engine link
// Start strobe, combinational word fetch, busy/done status and the result
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

interface stringPort #(
	parameter int maxWords = stringAccelPkg::MAX_WORDS
) ();
	import stringAccelPkg::*;

	// Word select width, at least one bit
	localparam int idxWidth = (maxWords > 1) ? $clog2(maxWords) : 1;

	// One-cycle launch from the register block
	logic start;

	// Engine picks a word, registers return A and B at that word
	logic [idxWidth-1:0] wordIndex;
	logic [31:0]         wordA;
	logic [31:0]         wordB;

	// Engine status, done is a single-cycle pulse
	logic       busy;
	logic       done;
	strResult_t result;

	modport regs (output start, wordA, wordB, input wordIndex, busy, done, result);

	modport engine (input start, wordA, wordB, output wordIndex, busy, done, result);

endinterface

`default_nettype wire

/* stringRegs.sv */
// ==========================================================================
// String accelerator register block
// Holds strings A and B and the control/status word behind a strobe bus
// with one-cycle registered read data, and launches the compare engine
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module stringRegs #(
	parameter int maxWords = stringAccelPkg::MAX_WORDS,
	localparam int addrWidth = $clog2(2 * maxWords + 1)
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [addrWidth-1:0] address,
	input  logic                 write,
	input  logic                 read,
	input  logic                 chipselect,
	input  logic [31:0]          writedata,
	output logic [31:0]          readdata,
	stringPort.regs              port
);
	import stringAccelPkg::*;

	localparam int idxWidth = (maxWords > 1) ? $clog2(maxWords) : 1;

	// String storage, word 0 carries bytes 0..3 little-endian
	logic [31:0] stringA [0:maxWords-1];
	logic [31:0] stringB [0:maxWords-1];

	// Control/status word
	logic [31:0] ctrlReg;

	// Address decode
	logic ctrlSel;
	logic aSel;
	logic bSel;
	logic [addrWidth-1:0] aOffset;
	logic [addrWidth-1:0] bOffset;

	// Access strobes
	logic busWrite;
	logic busRead;

	// Engine launched or still running
	logic active;

	// Region decode: 0 control, then A, then B
	assign ctrlSel = (address == '0);
	assign aSel = (int'(address) >= 1) && (int'(address) <= maxWords);
	assign bSel = (int'(address) > maxWords) && (int'(address) <= 2 * maxWords);

	// Word offsets within each array
	assign aOffset = address - addrWidth'(1);
	assign bOffset = address - addrWidth'(maxWords + 1);

	assign busWrite = chipselect && write;
	assign busRead = chipselect && read;

	// go covers the gap between the go write and the engine raising busy
	assign active = ctrlReg[CTRL_GO] || port.busy;

	// Word fetch for the engine
	assign port.wordA = stringA[port.wordIndex];
	assign port.wordB = stringB[port.wordIndex];

	// String arrays, frozen while a compare runs
	always_ff @(posedge clk) begin
		if (reset) begin
			stringA <= '{default: 32'h0};
			stringB <= '{default: 32'h0};
		end else if (busWrite && !active) begin
			if (aSel) begin
				stringA[aOffset[idxWidth-1:0]] <= writedata;
			end
			if (bSel) begin
				stringB[bOffset[idxWidth-1:0]] <= writedata;
			end
		end
	end

	// Control/status word and start strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrlReg <= '0;
			port.start <= 1'b0;
		end else begin
			// Launch on a go write to an idle engine, one cycle later
			port.start <= busWrite && ctrlSel && writedata[CTRL_GO] && !active;
			if (port.done) begin
				// Engine finished, publish results and drop go
				ctrlReg[CTRL_GO] <= 1'b0;
				ctrlReg[CTRL_DONE] <= 1'b1;
				ctrlReg[CTRL_MATCH] <= port.result.match;
				ctrlReg[CTRL_INDEX_LSB +: LEN_WIDTH] <= port.result.index;
				ctrlReg[CTRL_LENGTH_LSB +: LEN_WIDTH] <= port.result.length;
			end else if (busWrite && ctrlSel && !active) begin
				// Host write, done always cleared
				ctrlReg <= writedata;
				ctrlReg[CTRL_DONE] <= 1'b0;
			end
		end
	end

	// Registered read data, held until the next read
	always_ff @(posedge clk) begin
		if (reset) begin
			readdata <= '0;
		end else if (busRead) begin
			if (ctrlSel) begin
				readdata <= ctrlReg;
			end else if (aSel) begin
				readdata <= stringA[aOffset[idxWidth-1:0]];
			end else if (bSel) begin
				readdata <= stringB[bOffset[idxWidth-1:0]];
			end else begin
				// Unmapped address
				readdata <= '0;
			end
		end
	end

endmodule

`default_nettype wire
